// ==== source/cic_pkg.sv ====
// CIC datapath types
package cic_pkg;

    // word widths of the audio path.
    localparam int sample_w = 16;                 // audio sample at both ports.
    localparam int acc_w    = 24;                 // comb and integrator word.

    // filter shape. the DC gain is (R*M)^N / R, which is R for these values.
    localparam int cic_order  = 2;                // number of comb and integrator stages.
    localparam int comb_depth = 1;                // differential delay of each comb.

    // signed audio sample as it enters and leaves the chip.
    typedef logic signed [sample_w-1:0] sample_t;

    // internal word. full scale times a rate of 8 needs 19 bits, the rest is guard.
    typedef logic signed [acc_w-1:0] acc_t;

    // interpolation factor, legal range 1 to 8.
    typedef logic [3:0] rate_t;

    // system clocks per output sample.
    typedef logic [7:0] div_t;

    // arithmetic right shift applied before saturation.
    typedef logic [4:0] shift_t;

    // saturation limits, held in accumulator width so the compare stays signed.
    localparam acc_t sample_max = acc_t'(32767);
    localparam acc_t sample_min = acc_t'(-32768);

endpackage

// ==== source/cic_regs_pkg.sv ====
// CIC register map
package cic_regs_pkg;

    // AXI4-Lite word types.
    typedef logic [7:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t resp_okay   = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

    // register addresses, one word apart.
    localparam axi_addr_t addr_ctrl   = 8'h00;     // enable and clear.
    localparam axi_addr_t addr_rate   = 8'h04;     // interpolation factor R.
    localparam axi_addr_t addr_div    = 8'h08;     // clocks per output sample.
    localparam axi_addr_t addr_shift  = 8'h0C;     // output gain shift.
    localparam axi_addr_t addr_status = 8'h10;     // sticky overflow.
    localparam axi_addr_t addr_id     = 8'h14;     // read-only identification.

    // ascii "CIC2", the order is in the last character.
    localparam axi_data_t id_value = 32'h4349_4332;

    // field positions.
    localparam int ctrl_enable_bit = 0;
    localparam int ctrl_clear_bit  = 1;
    localparam int status_ovf_bit  = 0;

    // reset values and the limits that writes are clamped to.
    localparam int rate_reset  = 2;
    localparam int div_reset   = 4;
    localparam int shift_reset = 1;
    localparam int rate_min    = 1;
    localparam int rate_max    = 8;
    localparam int div_min     = 2;                // one clock of gap between output strobes.

endpackage

// ==== source/cic_cfg_if.sv ====
// CIC configuration interface
interface cic_cfg_if
    import cic_pkg::*;
();

    logic   enable;                               // runs the strobe generator.
    logic   clear;                                // one-cycle flush of the filter state.
    rate_t  rate;                                 // interpolation factor, already clamped.
    div_t   out_div;                              // clocks per output sample, at least 2.
    shift_t shift;                                // output gain shift.
    logic   overflow;                             // pulses once per clipped output sample.

    // register block owns the settings and watches for clipping.
    modport regs (
        output enable, clear, rate, out_div, shift,
        input  overflow
    );

    // strobe generator only needs the rates.
    modport timing (
        input enable, rate, out_div
    );

    // integrator side of the filter.
    modport datapath (
        input  clear, shift,
        output overflow
    );

endinterface

// ==== source/cic_regs.sv ====
// CIC AXI4-Lite register block
module cic_regs
    import cic_pkg::*;
    import cic_regs_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready,
    cic_cfg_if.regs   cfg
);

    logic      wr_fire;                           // address and data accepted together.
    logic      rd_fire;                           // read address accepted.
    logic      wr_known;                          // write address hits the map.
    logic      rd_known;                          // read address hits the map.
    axi_data_t rd_word;                           // read mux output.

    logic      enable_q;
    logic      clear_q;
    logic      ovf_q;
    rate_t     rate_q;
    div_t      div_q;
    shift_t    shift_q;

    // R outside 1..8 is pulled to the nearest end.
    function automatic rate_t clamp_rate(input axi_data_t value);
        if (value < rate_min) return rate_t'(rate_min);
        if (value > rate_max) return rate_t'(rate_max);
        return rate_t'(value);
    endfunction

    // a divider of 0 or 1 would leave no gap between output strobes.
    function automatic div_t clamp_div(input axi_data_t value);
        if (value > 32'd255) return '1;
        if (value < div_min) return div_t'(div_min);
        return div_t'(value);
    endfunction

    // address and data must arrive together, and only one response is in flight.
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign wr_fire = awready;
    assign arready = !rvalid;                     // one read outstanding at a time.
    assign rd_fire = arvalid && arready;

    always_comb begin
        case (awaddr)
            addr_ctrl, addr_rate, addr_div, addr_shift, addr_status, addr_id: wr_known = 1'b1;
            default: wr_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b0;
            clear_q  <= 1'b0;
            ovf_q    <= 1'b0;
            rate_q   <= rate_t'(rate_reset);
            div_q    <= div_t'(div_reset);
            shift_q  <= shift_t'(shift_reset);
        end else begin
            clear_q <= 1'b0;                      // clear lasts a single cycle.
            if (wr_fire) begin
                case (awaddr)
                    addr_ctrl: begin
                        enable_q <= wdata[ctrl_enable_bit];
                        clear_q  <= wdata[ctrl_clear_bit];
                    end
                    addr_rate:   rate_q  <= clamp_rate(wdata);
                    addr_div:    div_q   <= clamp_div(wdata);
                    addr_shift:  shift_q <= shift_t'(wdata);
                    addr_status: if (wdata[status_ovf_bit]) ovf_q <= 1'b0;
                    default: ;                    // the ID word is read-only.
                endcase
            end
            // a new clip in the same cycle as the clearing write keeps the flag set.
            if (cfg.overflow) ovf_q <= 1'b1;
        end
    end

    // write response.
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) bresp <= wr_known ? resp_okay : resp_slverr;
    end

    // read mux. unused bits read as zero.
    always_comb begin
        rd_known = 1'b1;
        rd_word  = '0;
        case (araddr)
            addr_ctrl:   rd_word[ctrl_enable_bit] = enable_q;   // clear always reads 0.
            addr_rate:   rd_word = axi_data_t'(rate_q);
            addr_div:    rd_word = axi_data_t'(div_q);
            addr_shift:  rd_word = axi_data_t'(shift_q);
            addr_status: rd_word[status_ovf_bit] = ovf_q;
            addr_id:     rd_word = id_value;
            default:     rd_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;                       // data follows the address by one cycle.
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_known ? resp_okay : resp_slverr;
        end
    end

    assign cfg.enable  = enable_q;
    assign cfg.clear   = clear_q;
    assign cfg.rate    = rate_q;
    assign cfg.out_div = div_q;
    assign cfg.shift   = shift_q;

endmodule

// ==== source/cic_cen_gen.sv ====
// CIC clock enable generator
module cic_cen_gen
    import cic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    cic_cfg_if.timing  cfg,
    output logic       cen_out,                   // one clock in every out_div.
    output logic       cen_in                     // on every R-th cen_out.
);

    div_t  div_cnt;                               // clocks left until the next output strobe.
    rate_t phase;                                 // output strobes since the last input strobe.
    logic  div_done;

    assign div_done = (div_cnt == '0);

    // both counters park at zero while disabled, so the first strobe
    // lands one cycle after enable rises and carries an input sample.
    always_ff @(posedge clk) begin
        if (rst || !cfg.enable) begin
            div_cnt <= '0;
            phase   <= '0;
            cen_out <= 1'b0;
            cen_in  <= 1'b0;
        end else begin
            cen_out <= div_done;
            cen_in  <= div_done && (phase == '0);
            if (div_done) begin
                div_cnt <= cfg.out_div - 1'b1;
                // >= keeps the phase in range if R shrinks while running.
                if (phase >= cfg.rate - 1'b1) begin
                    phase <= '0;
                end else begin
                    phase <= phase + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== source/cic_comb_chain.sv ====
// CIC comb chain
module cic_comb_chain
    import cic_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cen_in,                       // input sample rate.
    input  sample_t snd_in,
    output acc_t    comb_out
);

    // stage_in[k] feeds comb k, the last entry is the chain output.
    acc_t stage_in [cic_order+1];

    assign stage_in[0] = acc_t'(snd_in);          // sign extension to the wide word.

    for (genvar k = 0; k < cic_order; k++) begin : g_comb
        acc_t dly [comb_depth];                   // last comb_depth inputs of this stage.
        acc_t diff_q;

        // y[n] = x[n] - x[n-M], registered, advancing only on input samples.
        always_ff @(posedge clk) begin
            if (rst) begin
                diff_q <= '0;
                for (int d = 0; d < comb_depth; d++) begin
                    dly[d] <= '0;
                end
            end else if (cen_in) begin
                diff_q <= stage_in[k] - dly[comb_depth-1];
                dly[0] <= stage_in[k];
                for (int d = 1; d < comb_depth; d++) begin
                    dly[d] <= dly[d-1];
                end
            end
        end

        assign stage_in[k+1] = diff_q;
    end

    assign comb_out = stage_in[cic_order];

endmodule

// ==== source/cic_upsampler.sv ====
// CIC zero stuffer and integrators
module cic_upsampler
    import cic_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cen_out,                 // output sample rate.
    input  logic         stuff_phase,             // high on the output strobe that takes a sample.
    input  acc_t         comb_in,
    cic_cfg_if.datapath  cfg,
    output sample_t      snd_out,
    output logic         snd_out_valid
);

    acc_t stuffed_q;                              // comb word or an inserted zero.
    acc_t integ_q [cic_order];                    // running sums, the last one is the output.
    acc_t scaled;
    logic clip_hi;
    logic clip_lo;

    // the zero stuffer and the integrators all step on the output strobe.
    // a clear flushes them at once, whatever the strobes are doing.
    always_ff @(posedge clk) begin
        if (rst || cfg.clear) begin
            stuffed_q <= '0;
            for (int k = 0; k < cic_order; k++) begin
                integ_q[k] <= '0;
            end
        end else if (cen_out) begin
            stuffed_q  <= stuff_phase ? comb_in : '0;
            integ_q[0] <= integ_q[0] + stuffed_q;
            for (int k = 1; k < cic_order; k++) begin
                integ_q[k] <= integ_q[k] + integ_q[k-1];
            end
        end
    end

    // undo part of the gain of R, then see whether the result fits 16 bits.
    assign scaled  = integ_q[cic_order-1] >>> cfg.shift;
    assign clip_hi = scaled > sample_max;
    assign clip_lo = scaled < sample_min;

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_out       <= '0;
            snd_out_valid <= 1'b0;
            cfg.overflow  <= 1'b0;
        end else begin
            snd_out_valid <= cen_out;             // exactly one cycle per output strobe.
            cfg.overflow  <= cen_out && (clip_hi || clip_lo);
            if (cen_out) begin
                if (clip_hi) begin
                    snd_out <= sample_t'(sample_max);
                end else if (clip_lo) begin
                    snd_out <= sample_t'(sample_min);
                end else begin
                    snd_out <= sample_t'(scaled);
                end
            end
        end
    end

endmodule

// ==== source/cic_interp_top.sv ====
// CIC interpolator top level
module cic_interp_top
    import cic_pkg::*;
    import cic_regs_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready,
    input  sample_t   snd_in,
    output logic      sample_req,                 // snd_in is taken on this strobe.
    output sample_t   snd_out,
    output logic      snd_out_valid
);

    logic cen_in;
    logic cen_out;
    logic comb_rst;
    acc_t comb_word;

    cic_cfg_if cfg ();

    // the comb history must be flushed along with the integrators,
    // otherwise the old input level stays behind as a DC offset.
    assign comb_rst   = rst || cfg.clear;
    assign sample_req = cen_in;

    cic_regs i_regs (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cfg     (cfg.regs)
    );

    cic_cen_gen i_cen_gen (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg.timing),
        .cen_out (cen_out),
        .cen_in  (cen_in)
    );

    cic_comb_chain i_comb_chain (
        .clk      (clk),
        .rst      (comb_rst),
        .cen_in   (cen_in),
        .snd_in   (snd_in),
        .comb_out (comb_word)
    );

    // cen_in is a registered strobe that coincides with cen_out, so it marks the stuffer phase.
    cic_upsampler i_upsampler (
        .clk           (clk),
        .rst           (rst),
        .cen_out       (cen_out),
        .stuff_phase   (cen_in),
        .comb_in       (comb_word),
        .cfg           (cfg.datapath),
        .snd_out       (snd_out),
        .snd_out_valid (snd_out_valid)
    );

endmodule

// ==== testbench/cic_interp_properties.sv ====
// CIC handshake and strobe checks
module cic_interp_properties (
    input logic clk,
    input logic rst,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic snd_out_valid,
    input logic sample_req,
    input logic enable
);

    timeunit 1ns;
    timeprecision 1ps;

    // a write response stays up until the master takes it.
    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // out_div is at least 2, so output strobes always have a gap.
    valid_gap: assert property (@(posedge clk) disable iff (rst)
        snd_out_valid |=> !snd_out_valid)
        else $error("snd_out_valid high in two consecutive cycles");

    // strobes are registered, so they stop one cycle after enable falls.
    req_idle: assert property (@(posedge clk) disable iff (rst)
        !enable |=> !sample_req)
        else $error("sample_req while the datapath is disabled");

endmodule

// enable lives in the configuration interface inside the top level.
bind cic_interp_top cic_interp_properties i_properties (
    .clk           (clk),
    .rst           (rst),
    .bvalid        (bvalid),
    .bready        (bready),
    .rvalid        (rvalid),
    .rready        (rready),
    .snd_out_valid (snd_out_valid),
    .sample_req    (sample_req),
    .enable        (cfg.enable)
);

// ==== testbench/cic_interp_tb.sv ====
// CIC interpolator testbench
module cic_interp_tb
    import cic_pkg::*;
    import cic_regs_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // one stimulus row; result is the settled snd_out.
    typedef struct {
        int rate;
        int div;
        int shift;
        int snd;
        int result;
    } row_t;

    localparam int num_rows    = 7;
    localparam int cycle_limit = num_rows * 10 * 8 * 255 + 60000;   // rows plus the other tests.
    localparam int random_seed = 99261;
    localparam axi_data_t ctrl_run   = axi_data_t'(1 << ctrl_enable_bit);
    localparam axi_data_t ctrl_flush = axi_data_t'(1 << ctrl_clear_bit);
    localparam axi_data_t ovf_bit    = axi_data_t'(1 << status_ovf_bit);

    // rows 4 and 5 are near full scale with a small shift, so they clip.
    row_t rows [num_rows] = '{
        '{2, 4, 1,   1000,   1000},
        '{4, 3, 2,  -1234,  -1234},
        '{8, 2, 3,   5000,   5000},
        '{3, 5, 0,    300,    900},
        '{8, 2, 1,  30000,  32767},
        '{5, 6, 1, -20000, -32768},
        '{1, 2, 0,     -7,     -7}
    };

    logic      clk;
    logic      rst;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    sample_t   snd_in;
    logic      sample_req;
    sample_t   snd_out;
    logic      snd_out_valid;

    int        errors;
    int        checks;
    int        cycle_count;
    int        rnd_div;
    sample_t   held_out;                          // snd_out at the moment enable drops.

    cic_interp_top i_cic_interp_top (
        .clk           (clk),
        .rst           (rst),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .snd_in        (snd_in),
        .sample_req    (sample_req),
        .snd_out       (snd_out),
        .snd_out_valid (snd_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                   // 100 ns period.
    end

    // run limit, counted in clock cycles.
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d errors so far", cycle_count, errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // DC gain of the filter is R, then the shift and the 16-bit clamp.
    function automatic int expected_out(input int rate, input int shift, input int snd);
        int full;
        full = (snd * rate) >>> shift;
        if (full > 32767) return 32767;
        if (full < -32768) return -32768;
        return full;
    endfunction

    function automatic bit clips(input int rate, input int shift, input int snd);
        int full;
        full = (snd * rate) >>> shift;
        return (full > 32767) || (full < -32768);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    // all tasks start and end 10 ns after a rising edge.
    task automatic next_drive_point();
        @(posedge clk);
        #10;
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             input axi_resp_t want_resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_value("wready", 32'(wready), 32'd1);
        next_drive_point();                       // handshake happens on this edge.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        check_value("bresp", 32'(bresp), 32'(want_resp));
        next_drive_point();                       // the response has to wait one cycle.
        bready = 1'b1;
        next_drive_point();
        bready = 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
                            output axi_resp_t resp);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        next_drive_point();
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        next_drive_point();                       // read data is held back for one cycle.
        rready = 1'b1;
        next_drive_point();
        rready = 1'b0;
    endtask

    task automatic check_read(input string name, input axi_addr_t addr,
                              input axi_data_t want, input axi_resp_t want_resp);
        axi_data_t data;
        axi_resp_t resp;
        axi_read(addr, data, resp);
        check_value(name, data, want);
        check_value({name, "_rresp"}, 32'(resp), 32'(want_resp));
    endtask

    task automatic wait_requests(input int count);
        repeat (count) begin
            @(negedge clk);
            while (!sample_req) @(negedge clk);
        end
        next_drive_point();
    endtask

    // compares snd_out on each of the next count output strobes.
    task automatic check_outputs(input int count, input int want);
        repeat (count) begin
            @(negedge clk);
            while (!snd_out_valid) @(negedge clk);
            check_value("snd_out", 32'(snd_out), want);
        end
        next_drive_point();
    endtask

    // counts output strobes between sample requests, with a new random sample on each.
    task automatic count_outputs(input int rate, input int intervals);
        int pulses;
        int seen;
        pulses = 0;
        seen   = 0;
        while (seen <= intervals) begin
            @(negedge clk);
            if (snd_out_valid) pulses++;
            if (sample_req) begin
                if (seen > 0) check_value("pulses_per_request", pulses, rate);
                pulses = 0;
                seen++;
                next_drive_point();               // the old sample was taken on this edge.
                snd_in = sample_t'($urandom);
            end
        end
    endtask

    initial begin
        void'($urandom(random_seed));
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        rst         = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        snd_in      = '0;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        // reset values of the whole map.
        check_read("ctrl", addr_ctrl, '0, resp_okay);
        check_read("rate", addr_rate, 32'd2, resp_okay);
        check_read("div", addr_div, 32'd4, resp_okay);
        check_read("shift", addr_shift, 32'd1, resp_okay);
        check_read("status", addr_status, '0, resp_okay);
        check_read("id", addr_id, id_value, resp_okay);

        // read back, clamping, and the unmapped address.
        axi_write(addr_rate, 32'd5, resp_okay);
        check_read("rate", addr_rate, 32'd5, resp_okay);
        axi_write(addr_rate, 32'd0, resp_okay);
        check_read("rate_low", addr_rate, 32'd1, resp_okay);
        axi_write(addr_rate, 32'd9, resp_okay);
        check_read("rate_high", addr_rate, 32'd8, resp_okay);
        axi_write(addr_div, 32'd1, resp_okay);
        check_read("div_low", addr_div, 32'd2, resp_okay);
        axi_write(addr_div, 32'd77, resp_okay);
        check_read("div", addr_div, 32'd77, resp_okay);
        axi_write(addr_shift, 32'd6, resp_okay);
        check_read("shift", addr_shift, 32'd6, resp_okay);
        axi_write(addr_ctrl, ctrl_run | ctrl_flush, resp_okay);
        check_read("ctrl", addr_ctrl, ctrl_run, resp_okay);   // clear is self-clearing.
        axi_write(addr_ctrl, '0, resp_okay);
        axi_write(8'h18, 32'hDEAD_BEEF, resp_slverr);
        check_read("unmapped", 8'h18, '0, resp_slverr);

        // settled output and overflow flag for each table row.
        for (int i = 0; i < num_rows; i++) begin
            check_value("table_result", rows[i].result,
                        expected_out(rows[i].rate, rows[i].shift, rows[i].snd));
            axi_write(addr_ctrl, '0, resp_okay);
            axi_write(addr_rate, axi_data_t'(rows[i].rate), resp_okay);
            axi_write(addr_div, axi_data_t'(rows[i].div), resp_okay);
            axi_write(addr_shift, axi_data_t'(rows[i].shift), resp_okay);
            axi_write(addr_ctrl, ctrl_flush, resp_okay);
            axi_write(addr_status, ovf_bit, resp_okay);
            snd_in = sample_t'(rows[i].snd);
            axi_write(addr_ctrl, ctrl_run, resp_okay);
            wait_requests(10);
            check_outputs(2 * rows[i].rate, rows[i].result);
            check_read("status", addr_status,
                       clips(rows[i].rate, rows[i].shift, rows[i].snd) ? ovf_bit : '0,
                       resp_okay);
            axi_write(addr_ctrl, '0, resp_okay);
            axi_write(addr_status, ovf_bit, resp_okay);
            check_read("status_cleared", addr_status, '0, resp_okay);
        end

        // every rate, random divider and random samples.
        axi_write(addr_shift, 32'd3, resp_okay);
        for (int r = 1; r <= 8; r++) begin
            rnd_div = 2 + int'($urandom % 6);
            axi_write(addr_ctrl, '0, resp_okay);
            axi_write(addr_rate, axi_data_t'(r), resp_okay);
            axi_write(addr_div, axi_data_t'(rnd_div), resp_okay);
            axi_write(addr_ctrl, ctrl_flush, resp_okay);
            snd_in = sample_t'($urandom);
            axi_write(addr_ctrl, ctrl_run, resp_okay);
            count_outputs(r, 6);
        end

        // disabled chip stays silent and holds its output.
        axi_write(addr_ctrl, '0, resp_okay);
        repeat (4) next_drive_point();            // let the last strobes drain.
        held_out = snd_out;
        repeat (1000) begin
            @(negedge clk);
            check_value("sample_req", 32'(sample_req), '0);
            check_value("snd_out_valid", 32'(snd_out_valid), '0);
            check_value("snd_out_held", 32'(snd_out), 32'(held_out));
        end

        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle_count);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
source/cic_pkg.sv
source/cic_regs_pkg.sv
source/cic_cfg_if.sv
source/cic_regs.sv
source/cic_cen_gen.sv
source/cic_comb_chain.sv
source/cic_upsampler.sv
source/cic_interp_top.sv
testbench/cic_interp_properties.sv
testbench/cic_interp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CIC interpolator testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cic_interp_tb -f compile.f -o sim_cic > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/sim_cic > sim.log 2>&1 || true
cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && exit 0 || exit 1
